// File: verification/spi_tests.txt
// columns: control  tx_word  slave_response  expected_rx  expected_mosi (all hex)
// control bit 31 adds a second data write during the transfer, control ffffffff ends the list
00000009 123456a5 cafe003c 0000003c 000000a5
0000100a 0000005a 000000c3 000000c3 0000005a
0000200c 000000f0 0000000f 0000000f 000000f0
0000300b 00000081 0000007e 0000007e 00000081
00000069 ffffbeef 00001234 00001234 0000beef
00000029 1111c0de 5678aa55 0000aa55 0000c0de
00001069 0000a55a 00003cc3 00003cc3 0000a55a
00000059 deadbeef 01234567 01234567 deadbeef
00000051 deadbeef 01234567 01234567 deadbeef
00003019 89abcdef fedcba98 fedcba98 89abcdef
00003011 89abcdef fedcba98 fedcba98 89abcdef
00002061 0000a55a 00003cc3 00003cc3 0000a55a
00002069 0000a55a 00003cc3 00003cc3 0000a55a
80000069 0000a1b2 0000c3d4 0000c3d4 0000a1b2
80003051 13579bdf 2468ace0 2468ace0 13579bdf
00000039 00000077 00000088 00000088 00000077
00000001 00000000 ffffffff 000000ff 00000000
ffffffff ffffffff ffffffff ffffffff ffffffff

// File: filelist.f
+incdir+logic
logic/spi_pkg.sv
logic/spi_regs.sv
logic/spi_sclk_gen.sv
logic/spi_shifter.sv
logic/spi_device.sv
verification/spi_device_asserts.sv
verification/spi_device_tb.sv

// File: Makefile
TOP := spi_device_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module spi_device -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

// File: verification/spi_device_tb.sv
// spi master testbench: clock, reset, bus tasks, spi slave model, file-driven tests, report
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_device_tb;

  localparam int POLL_LIMIT  = 40 * `SPI_SLOW_DIV + 50;   // status polls of 2 cycles each
  localparam int SLAVE_LIMIT = 80 * `SPI_SLOW_DIV + 100;  // cycles for one whole transfer

  logic           clk;
  logic           rst;
  logic           stb;
  logic           we;
  logic           addr;
  spi_pkg::word_t data_in;
  spi_pkg::word_t data_out;
  logic           ack;
  spi_pkg::cs_t   cs_n;
  logic           sclk;
  logic           mosi;
  logic           miso;

  spi_pkg::word_t vecs [0:255];  // five words per test
  spi_pkg::word_t st;
  logic [7:0]     base;
  int             errors;
  int             err_before;
  int             pass_count;
  int             fail_count;
  int             tnum;
  int             seed;
  bit             timed_out;

  spi_device dut_i (
    .clk(clk), .rst(rst),
    .stb(stb), .we(we), .addr(addr), .data_in(data_in),
    .data_out(data_out), .ack(ack),
    .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso)
  );

  bind spi_device spi_device_asserts asserts_i (
    .clk(clk), .rst(rst), .stb(stb), .ack(ack), .cs_n(cs_n), .sclk(sclk),
    .mode(mode), .start(start), .run(run), .rdy(rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check_value(input string name, input spi_pkg::word_t got,
                             input spi_pkg::word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one bus cycle with inputs changing 2 ns after the edge
  task automatic bus_write(input logic a, input spi_pkg::word_t d);
    @(posedge clk);
    #2;
    stb = 1'b1;
    we = 1'b1;
    addr = a;
    data_in = d;
    @(negedge clk);
    check_value("ack", {31'h0, ack}, 32'h1);
    @(posedge clk);
    #2;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input logic a, output spi_pkg::word_t d);
    @(posedge clk);
    #2;
    stb = 1'b1;
    we = 1'b0;
    addr = a;
    @(negedge clk);
    d = data_out;  // sampled mid-cycle once settled
    check_value("ack", {31'h0, ack}, 32'h1);
    @(posedge clk);
    #2;
    stb = 1'b0;
  endtask

  task automatic wait_ready(output spi_pkg::word_t s, output bit ready);
    int polls;
    ready = 1'b0;
    polls = 0;
    s = '0;
    while (!ready && polls < POLL_LIMIT) begin
      bus_read(1'b1, s);
      ready = s[0];
      polls++;
    end
    if (!ready) begin
      $display("timeout: rdy stayed low for %0d status polls", POLL_LIMIT);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  // k-th bit on the wire -> bit position in the word
  function automatic logic [4:0] wire_bit_pos(input int k, input int nbytes, input logic msb);
    int byte_idx;
    byte_idx = msb ? nbytes - 1 - k / 8 : k / 8;
    return 5'(8 * byte_idx + 7 - k % 8);  // msb of each byte first
  endfunction

  // slave side of one transfer with edges seen at mid-cycle
  task automatic slave_transfer(input spi_pkg::word_t ctrl, input spi_pkg::word_t resp,
                                output spi_pkg::word_t cap);
    int         nbytes;
    int         nbits;
    int         sent;
    int         got;
    int         cyc;
    logic       cpol;
    logic       cpha;
    logic       msb;
    logic       prev;
    logic       now_s;
    logic [4:0] pos;
    nbytes = (ctrl[5:4] == 2'd1) ? 4 : (ctrl[5:4] == 2'd2) ? 2 : 1;
    nbits = 8 * nbytes;
    cpol = ctrl[12];
    cpha = ctrl[13];
    msb = ctrl[6];
    cap = '0;
    sent = 0;
    got = 0;
    cyc = 0;
    prev = sclk;
    if (!cpha) begin
      pos = wire_bit_pos(0, nbytes, msb);  // first bit ready before any edge
      miso = resp[pos];
      sent = 1;
    end
    while (got < nbits && cyc < SLAVE_LIMIT) begin
      @(negedge clk);
      cyc++;
      now_s = sclk;
      if (now_s !== prev) begin
        if ((now_s !== cpol) == cpha) begin
          // next bit out on a cpha 1 leading or cpha 0 trailing edge
          if (sent < nbits) begin
            pos = wire_bit_pos(sent, nbytes, msb);
            miso = resp[pos];
            sent++;
          end
        end else begin
          pos = wire_bit_pos(got, nbytes, msb);
          cap[pos] = mosi;
          got++;
        end
      end
      prev = now_s;
    end
    miso = 1'b0;
    if (got != nbits) begin
      $display("timeout: slave saw %0d of %0d sample edges", got, nbits);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic run_transfer(input spi_pkg::word_t ctrl, input spi_pkg::word_t tx,
                              input spi_pkg::word_t resp, input spi_pkg::word_t exp_rx,
                              input spi_pkg::word_t exp_mosi);
    spi_pkg::word_t s;
    spi_pkg::word_t rx;
    spi_pkg::word_t cap;
    spi_pkg::word_t busy_word;
    bit             ready;
    busy_word = $random(seed);
    bus_write(1'b1, ctrl);
    check_value("cs_n", {29'h0, cs_n}, {29'h0, ~ctrl[2:0]});
    wait_ready(s, ready);
    if (!ready) begin
      return;
    end
    check_value("status", s, (ctrl & 32'h0000_3000) | 32'h1);  // mode and rdy only
    check_value("sclk idle", {31'h0, sclk}, {31'h0, ctrl[12]});
    rx = '0;
    fork
      slave_transfer(ctrl, resp, cap);
      begin
        bus_write(1'b0, tx);
        if (ctrl[31]) begin
          bus_write(1'b0, busy_word);  // lands mid-transfer and must be dropped
        end
        bus_read(1'b1, s);
        check_value("rdy after data write", {31'h0, s[0]}, 32'h0);
        wait_ready(s, ready);
        bus_read(1'b0, rx);
      end
    join
    check_value("rx_word", rx, exp_rx);
    check_value("mosi word", cap, exp_mosi);
    check_value("sclk idle", {31'h0, sclk}, {31'h0, ctrl[12]});
    check_value("cs_n", {29'h0, cs_n}, {29'h0, ~ctrl[2:0]});
  endtask

  task automatic report_test(input int num, input int errs_at_start, input spi_pkg::word_t ctrl);
    if (errors == errs_at_start) begin
      pass_count++;
      $display("test %0d ctrl %h: pass", num, ctrl);
    end else begin
      fail_count++;
      $display("test %0d ctrl %h: fail", num, ctrl);
    end
  endtask

  initial begin
    rst = 1'b1;
    stb = 1'b0;
    we = 1'b0;
    addr = 1'b0;
    data_in = '0;
    miso = 1'b0;
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    timed_out = 1'b0;
    seed = 78;
    vecs = '{default: 32'hffff_ffff};  // reads as the end marker if the file is short
    $readmemh("verification/spi_tests.txt", vecs);
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // state straight out of reset
    err_before = errors;
    bus_read(1'b1, st);
    check_value("status after reset", st, 32'h1);
    check_value("cs_n after reset", {29'h0, cs_n}, 32'h7);
    check_value("sclk after reset", {31'h0, sclk}, 32'h0);
    report_test(0, err_before, 32'h0);

    base = 8'd0;
    tnum = 1;
    while (!timed_out && base <= 8'd250 && vecs[base] !== 32'hffff_ffff) begin
      err_before = errors;
      run_transfer(vecs[base], vecs[base + 8'd1], vecs[base + 8'd2], vecs[base + 8'd3],
                   vecs[base + 8'd4]);
      report_test(tnum, err_before, vecs[base]);
      base = base + 8'd5;
      tnum++;
    end
    if (tnum == 1) begin
      $display("no test lines read from the data file");
    end

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && !timed_out && tnum > 1) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verification/spi_device_asserts.sv
// concurrent checks on bus handshake, chip select, transfer start and sclk idle level
`timescale 1ns/10ps

module spi_device_asserts (
  input logic               clk,
  input logic               rst,
  input logic               stb,
  input logic               ack,
  input spi_pkg::cs_t       cs_n,
  input logic               sclk,
  input spi_pkg::spi_mode_t mode,
  input logic               start,
  input logic               run,
  input logic               rdy
);

  // same-cycle acknowledge
  ack_follows_stb: assert property (@(posedge clk) disable iff (rst) ack == stb)
    else $error("ack differs from stb");

  // select lines frozen while bits move
  cs_stable_in_transfer: assert property (@(posedge clk) disable iff (rst) run |-> $stable(cs_n))
    else $error("cs_n changed during a transfer");

  // a transfer only begins out of the ready state
  run_starts_from_ready: assert property (@(posedge clk) disable iff (rst) $rose(run) |-> $past(rdy))
    else $error("transfer started while rdy was low");

  // rdy only drops because of an accepted start
  rdy_falls_on_start: assert property (@(posedge clk) disable iff (rst) $fell(rdy) |-> $past(start))
    else $error("rdy fell without a start pulse");

  // idle sclk at cpol, one settle cycle after rdy rises
  sclk_idles_at_cpol: assert property (@(posedge clk) disable iff (rst)
    rdy && $past(rdy) |-> sclk == mode[0])
    else $error("sclk away from cpol while idle");

endmodule

// File: logic/spi_device.sv
// spi master top level: register front end, sclk generator and shift engine
`timescale 1ns/10ps

module spi_device (
  input  logic           clk,
  input  logic           rst,
  // host bus
  input  logic           stb,
  input  logic           we,
  input  logic           addr,
  input  spi_pkg::word_t data_in,
  output spi_pkg::word_t data_out,
  output logic           ack,
  // spi pins
  output spi_pkg::cs_t   cs_n,
  output logic           sclk,
  output logic           mosi,
  input  logic           miso
);

  // regs -> shifter / sclk gen
  logic                start;
  spi_pkg::word_t      tx_word;
  logic                fast;
  spi_pkg::width_sel_t width_sel;
  logic                msbyte_first;
  spi_pkg::spi_mode_t  mode;
  // shifter <-> sclk gen
  logic                run;
  logic                lead_edge;
  logic                trail_edge;
  // shifter -> regs
  logic                rdy;
  spi_pkg::word_t      rx_word;

  spi_regs regs_i (
    .clk(clk), .rst(rst),
    .stb(stb), .we(we), .addr(addr), .data_in(data_in),
    .data_out(data_out), .ack(ack),
    .rdy(rdy), .rx_word(rx_word),
    .start(start), .tx_word(tx_word), .cs_n(cs_n), .fast(fast),
    .width_sel(width_sel), .msbyte_first(msbyte_first), .mode(mode)
  );

  spi_sclk_gen sclk_gen_i (
    .clk(clk), .rst(rst),
    .run(run), .fast(fast), .mode(mode),
    .sclk(sclk), .lead_edge(lead_edge), .trail_edge(trail_edge)
  );

  spi_shifter shifter_i (
    .clk(clk), .rst(rst),
    .start(start), .tx_word(tx_word), .width_sel(width_sel),
    .msbyte_first(msbyte_first), .mode(mode),
    .lead_edge(lead_edge), .trail_edge(trail_edge), .miso(miso),
    .run(run), .rdy(rdy), .rx_word(rx_word), .mosi(mosi)
  );

endmodule

// File: logic/spi_shifter.sv
// spi shift engine: transfer fsm, bit counter, byte reordering, mosi shift and miso sample
`timescale 1ns/10ps

module spi_shifter (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  spi_pkg::word_t      tx_word,
  input  spi_pkg::width_sel_t width_sel,
  input  logic                msbyte_first,
  input  spi_pkg::spi_mode_t  mode,
  input  logic                lead_edge,
  input  logic                trail_edge,
  input  logic                miso,
  output logic                run,
  output logic                rdy,
  output spi_pkg::word_t      rx_word,
  output logic                mosi
);

  spi_pkg::shift_state_t state;
  spi_pkg::word_t        tx_sreg;     // next bit always at bit 31
  spi_pkg::word_t        rx_sreg;     // sampled bits enter at bit 0
  spi_pkg::word_t        tx_packed;   // tx_word with the first byte on top
  logic [5:0]            bit_cnt;     // bits still to sample
  spi_pkg::width_sel_t   width_q;     // transfer settings frozen at start
  logic                  msb_q;
  logic                  cpha_q;
  logic                  load;
  logic                  sample_edge;
  logic                  shift_edge;

  // bytes per transfer from the width code
  function automatic int byte_count(input spi_pkg::width_sel_t ws);
    case (ws)
      2'd1:    return 4;
      2'd2:    return 2;
      default: return 1;  // codes 0 and 3
    endcase
  endfunction

  // put the first byte to send on top and the following bytes below it
  function automatic spi_pkg::word_t pack_tx(input spi_pkg::word_t w, input int n,
                                             input logic msb);
    spi_pkg::word_t r;
    int             idx;
    r = '0;
    for (int k = 0; k < 4; k++) begin
      if (k < n) begin
        idx = msb ? n - 1 - k : k;  // k-th byte on the wire
        r[31 - 8*k -: 8] = w[8*idx +: 8];
      end
    end
    return r;
  endfunction

  // put received bytes back where they came from and right aligned
  function automatic spi_pkg::word_t unpack_rx(input spi_pkg::word_t w, input int n,
                                               input logic msb);
    spi_pkg::word_t r;
    int             idx;
    r = '0;
    for (int k = 0; k < 4; k++) begin
      if (k < n) begin
        idx = msb ? n - 1 - k : k;
        r[8*idx +: 8] = w[8*(n - 1 - k) +: 8];  // k-th byte received
      end
    end
    return r;
  endfunction

  assign tx_packed   = pack_tx(tx_word, byte_count(width_sel), msbyte_first);
  assign load        = start && (state == spi_pkg::idle);  // start dropped unless idle
  assign sample_edge = cpha_q ? trail_edge : lead_edge;
  assign shift_edge  = cpha_q ? lead_edge  : trail_edge;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= spi_pkg::idle;
      tx_sreg <= '0;
      rx_sreg <= '0;
      bit_cnt <= '0;
      width_q <= '0;
      msb_q   <= 1'b0;
      cpha_q  <= 1'b0;
      run     <= 1'b0;
      rdy     <= 1'b1;
      rx_word <= '0;
      mosi    <= 1'b0;
    end else begin
      case (state)
        spi_pkg::idle: begin
          if (load) begin
            width_q <= width_sel;
            msb_q   <= msbyte_first;
            cpha_q  <= mode[1];
            bit_cnt <= 6'(8 * byte_count(width_sel));
            rx_sreg <= '0;
            run     <= 1'b1;
            rdy     <= 1'b0;
            state   <= spi_pkg::shifting;
            if (!mode[1]) begin
              // cpha 0 presents the first bit before any edge
              mosi    <= tx_packed[31];
              tx_sreg <= {tx_packed[30:0], 1'b0};
            end else begin
              tx_sreg <= tx_packed;  // first bit goes out on the first leading edge
            end
          end
        end
        spi_pkg::shifting: begin
          if (shift_edge) begin
            mosi    <= tx_sreg[31];
            tx_sreg <= {tx_sreg[30:0], 1'b0};
          end
          if (sample_edge) begin
            rx_sreg <= {rx_sreg[30:0], miso};
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == 6'd1) begin
              run   <= 1'b0;  // last sample, sclk falls back to idle
              state <= spi_pkg::done_state;
            end
          end
        end
        spi_pkg::done_state: begin
          rx_word <= unpack_rx(rx_sreg, byte_count(width_q), msb_q);
          rdy     <= 1'b1;
          state   <= spi_pkg::idle;
        end
        default: begin
          state <= spi_pkg::idle;
        end
      endcase
    end
  end

endmodule

// File: logic/spi_sclk_gen.sv
// serial clock generator: half-period divider, sclk polarity and edge strobes
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_sclk_gen (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,     // high while the shifter is busy
  input  logic               fast,
  input  spi_pkg::spi_mode_t mode,    // only cpol matters here
  output logic               sclk,
  output logic               lead_edge,
  output logic               trail_edge
);

  localparam int FAST_DIV = `SPI_FAST_DIV;
  localparam int SLOW_DIV = `SPI_SLOW_DIV;
  localparam int CNT_W    = $clog2(SLOW_DIV + 1);

  logic [CNT_W-1:0] cnt;     // cycles left in this half period
  logic [CNT_W-1:0] reload;
  logic             phase;   // 0 idle half, 1 active half
  logic             tick;    // half period over

  assign reload = fast ? CNT_W'(FAST_DIV - 1) : CNT_W'(SLOW_DIV - 1);

  assign tick = run && (cnt == '0);

  // strobes mark the cycle whose closing edge flips sclk
  // the shifter acts on that same clock edge
  assign lead_edge  = tick && !phase;  // idle -> active
  assign trail_edge = tick &&  phase;  // active -> idle

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= CNT_W'(SLOW_DIV - 1);
      phase <= 1'b0;
    end else if (!run) begin
      // parked: full half period before the first edge
      cnt   <= reload;
      phase <= 1'b0;
    end else if (tick) begin
      cnt   <= reload;
      phase <= ~phase;
    end else begin
      cnt   <= cnt - 1'b1;
    end
  end

  // cpol flips the whole waveform, so idle level equals cpol
  assign sclk = phase ^ mode[0];

  // fast divisor 2 and slow divisor 16 with the default macros
  // i.e. slow runs at one eighth of the fast rate
  // run dropping mid half-period cuts sclk straight back to idle
  // which only happens after the last sample edge

endmodule

// File: logic/spi_regs.sv
// spi register front end: bus decode, control register, start pulse, cs drive, read mux
`timescale 1ns/10ps

module spi_regs (
  input  logic                clk,
  input  logic                rst,
  // host bus
  input  logic                stb,
  input  logic                we,
  input  logic                addr,          // 0 data, 1 control/status
  input  spi_pkg::word_t      data_in,
  output spi_pkg::word_t      data_out,
  output logic                ack,
  // from the shifter
  input  logic                rdy,
  input  spi_pkg::word_t      rx_word,
  // to the shifter and clock generator
  output logic                start,
  output spi_pkg::word_t      tx_word,
  output spi_pkg::cs_t        cs_n,
  output logic                fast,
  output spi_pkg::width_sel_t width_sel,
  output logic                msbyte_first,
  output spi_pkg::spi_mode_t  mode
);

  logic         rd_data;    // read received word
  logic         wr_data;    // write word to send, kicks a transfer
  logic         rd_ctrl;    // read status
  logic         wr_ctrl;    // write control
  spi_pkg::cs_t cs_sel;     // select field as written
  logic         status_rdy;

  // four access kinds
  assign rd_data = stb & ~we & ~addr;
  assign wr_data = stb &  we & ~addr;
  assign rd_ctrl = stb & ~we &  addr;
  assign wr_ctrl = stb &  we &  addr;

  // control register, reserved bits 11:7 not stored
  always_ff @(posedge clk) begin
    if (rst) begin
      cs_sel       <= '0;  // all lines deselected
      fast         <= 1'b0;
      width_sel    <= '0;  // 8 bits
      msbyte_first <= 1'b0;
      mode         <= '0;  // mode 0, sclk idles low
    end else if (wr_ctrl) begin
      cs_sel       <= data_in[2:0];
      fast         <= data_in[3];
      width_sel    <= data_in[5:4];
      msbyte_first <= data_in[6];
      mode         <= data_in[13:12];
    end
  end

  // start follows the data write by one cycle, together with tx_word
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
    end else begin
      start <= wr_data;
    end
  end

  // shifter copies tx_word at start, later writes only touch this copy
  always_ff @(posedge clk) begin
    if (wr_data) begin
      tx_word <= data_in;
    end
  end

  // start still on its way to the shifter, so report busy already
  assign status_rdy = rdy & ~start;

  assign cs_n = ~cs_sel;  // lines are active low
  assign ack  = stb;      // same-cycle acknowledge, no wait states

  always_comb begin
    data_out = '0;
    if (rd_data) begin
      data_out = rx_word;
    end else if (rd_ctrl) begin
      data_out = {18'h0, mode, 11'h0, status_rdy};  // mode at 13:12, rdy at 0
    end
  end

endmodule

// File: logic/spi_pkg.sv
// spi master types: data word, control field vectors and shifter state enum
package spi_pkg;

  // bus data and shift data, always a full word
  typedef logic [31:0] word_t;

  // one bit per chip-select line, active high in the register
  typedef logic [2:0] cs_t;

  // transfer width code
  //   0 -> 8 bits
  //   1 -> 32 bits
  //   2 -> 16 bits
  //   3 -> 8 bits as well
  typedef logic [1:0] width_sel_t;

  // bit 0 cpol, bit 1 cpha (control bits 12 and 13)
  typedef logic [1:0] spi_mode_t;

  // transfer fsm of the shift engine
  typedef enum logic [1:0] {
    idle,       // waiting for start, rdy high
    shifting,   // sclk running, bits moving
    done_state  // one cycle to unscramble rx bytes
  } shift_state_t;

  // bits per byte on the wire
  // used when loading the bit counter
  // wider words are just more bytes

endpackage

// File: logic/spi_cfg.svh
// clock rate macros for the spi master and derived half-period divisor counts
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// system clock feeding the whole block
`define SPI_CLK_HZ 50_000_000

// serial clock targets, selected by the fast control bit
`define SPI_FAST_HZ 12_500_000
`define SPI_SLOW_HZ 1_562_500

// half-period counts in system clock cycles
// 50 MHz system clock gives 2 for fast and 16 for slow
`define SPI_FAST_DIV (`SPI_CLK_HZ / (2 * `SPI_FAST_HZ))
`define SPI_SLOW_DIV (`SPI_CLK_HZ / (2 * `SPI_SLOW_HZ))

// control word bit positions
// [2:0]   chip select, one bit per line
// [3]     fast serial clock
// [5:4]   transfer width code
// [6]     most significant byte first
// [11:7]  reserved, dropped on write
// [13:12] spi mode, cpol low bit

// a fast divisor of zero would stall sclk
// keep SPI_FAST_HZ at or below a quarter of SPI_CLK_HZ

`endif
